// ==== list.f ====
+incdir+test
verilog/flush_pkg.sv
verilog/commit_event_decoder.sv
verilog/flush_controller.sv
verilog/dcache_flush_sequencer.sv
verilog/flush_unit_top.sv
test/tb_flush_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the flush unit testbench with Verilator and runs it
# Exit status is nonzero when the build fails or the simulation reports failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_flush_unit \
    -Mdir obj_dir \
    -o sim_flush_unit \
    -f list.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_flush_unit
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

echo "Simulation passed"
exit 0

// ==== test/flush_model.svh ====
// Flush unit reference model
// Expected flush strobes for each committed instruction class and the
// dirty-line state of the write-back data cache as the testbench sees it

`ifndef FLUSH_MODEL_SVH
`define FLUSH_MODEL_SVH

// Lines marked dirty since the last flush
logic [flush_pkg::DCACHE_LINES-1:0] model_dirty;

// Strobe order, msb first
// set_pc_commit, flush_if, flush_unissued_instr, flush_id, flush_ex,
// flush_bp, flush_icache, flush_tlb
function automatic logic [7:0] expected_flush(input flush_pkg::commit_op_e op);
    logic       restart;
    logic       trap;
    logic [7:0] vec;
    // Classes that restart fetch from the commit PC
    restart = (op == flush_pkg::OP_FENCE) || (op == flush_pkg::OP_FENCE_I) ||
              (op == flush_pkg::OP_SFENCE_VMA) || (op == flush_pkg::OP_CSR_WRITE);
    // Trap entry and return take the PC from elsewhere
    trap    = (op == flush_pkg::OP_EXCEPTION) || (op == flush_pkg::OP_ERET);
    vec     = 8'h00;
    if (op == flush_pkg::OP_BRANCH_MISS) begin
        vec[6:5] = 2'b11;
    end
    if (restart) begin
        vec[7:3] = 5'b11111;
    end
    if (op == flush_pkg::OP_FENCE_I) begin
        vec[1] = 1'b1;
    end
    if (op == flush_pkg::OP_SFENCE_VMA) begin
        vec[0] = 1'b1;
    end
    // Trap clears set_pc and adds the branch predictor flush
    if (trap) begin
        vec[7:2] = 6'b011111;
    end
    return vec;
endfunction

// Record one store to a line
function automatic void model_mark(input logic [flush_pkg::LINE_IDX_WIDTH-1:0] line);
    model_dirty[line] = 1'b1;
endfunction

// Number of lines a flush should write back
function automatic int model_dirty_count();
    int count;
    count = 0;
    for (int i = 0; i < flush_pkg::DCACHE_LINES; i++) begin
        if (model_dirty[i]) begin
            count++;
        end
    end
    return count;
endfunction

`endif

// ==== test/tb_flush_unit.sv ====
// Flush unit testbench
// Drives committed instructions, dirty marks and write-back back-pressure
// into the flush unit and compares strobes and write-backs with a model

`timescale 1ns/1ps

module tb_flush_unit;

    `include "flush_model.svh"

    localparam int NUM_RANDOM_OPS  = 40;
    localparam int NUM_DIRECTED    = 4;
    localparam int NUM_FENCES      = 7;
    localparam int TOTAL_INSTR     = NUM_RANDOM_OPS + NUM_DIRECTED + NUM_FENCES;
    localparam int WATCHDOG_CYCLES = 16 + 200 * TOTAL_INSTR +
                                     20 * flush_pkg::DCACHE_LINES * NUM_FENCES;

    logic                                 clk_i = 1'b0;
    logic                                 rst_ni;
    logic                                 commit_valid_i;
    logic [flush_pkg::OP_WIDTH-1:0]       commit_op_i;
    logic                                 commit_ready_o;
    logic                                 halt_csr_i;
    logic                                 mark_dirty_i;
    logic [flush_pkg::LINE_IDX_WIDTH-1:0] mark_line_i;
    logic                                 writeback_ready_i;
    logic                                 writeback_valid_o;
    logic [flush_pkg::LINE_IDX_WIDTH-1:0] writeback_line_o;
    logic                                 set_pc_commit_o;
    logic                                 flush_if_o;
    logic                                 flush_unissued_instr_o;
    logic                                 flush_id_o;
    logic                                 flush_ex_o;
    logic                                 flush_bp_o;
    logic                                 flush_icache_o;
    logic                                 flush_tlb_o;
    logic                                 flush_dcache_o;
    logic                                 halt_o;

    // Shared between stimulus and monitors
    int                                   error_count = 0;
    int                                   accepted_count = 0;
    logic                                 random_wb_ready = 1'b0;
    logic [flush_pkg::LINE_IDX_WIDTH-1:0] wb_seen[$];

    flush_unit_top u_dut (
        .clk_i                  (clk_i),
        .rst_ni                 (rst_ni),
        .commit_valid_i         (commit_valid_i),
        .commit_op_i            (commit_op_i),
        .commit_ready_o         (commit_ready_o),
        .halt_csr_i             (halt_csr_i),
        .mark_dirty_i           (mark_dirty_i),
        .mark_line_i            (mark_line_i),
        .writeback_ready_i      (writeback_ready_i),
        .writeback_valid_o      (writeback_valid_o),
        .writeback_line_o       (writeback_line_o),
        .set_pc_commit_o        (set_pc_commit_o),
        .flush_if_o             (flush_if_o),
        .flush_unissued_instr_o (flush_unissued_instr_o),
        .flush_id_o             (flush_id_o),
        .flush_ex_o             (flush_ex_o),
        .flush_bp_o             (flush_bp_o),
        .flush_icache_o         (flush_icache_o),
        .flush_tlb_o            (flush_tlb_o),
        .flush_dcache_o         (flush_dcache_o),
        .halt_o                 (halt_o)
    );

    // 20 ns period
    always #10 clk_i = ~clk_i;

    // ------------------------------
    // Failure reporting
    // ------------------------------
    task automatic fail_run(input string reason);
        error_count++;
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            fail_run($sformatf("MISMATCH %s got 0x%0h expected 0x%0h",
                               name, actual, expected));
        end
    endtask

    // ------------------------------
    // Stimulus helpers
    // ------------------------------
    // Hold one instruction until the port takes it, return in the strobe cycle
    task automatic issue_op(input flush_pkg::commit_op_e op);
        @(negedge clk_i);
        while (!commit_ready_o) begin
            @(negedge clk_i);
        end
        commit_valid_i = 1'b1;
        commit_op_i    = op;
        @(negedge clk_i);
        commit_valid_i = 1'b0;
        commit_op_i    = flush_pkg::OP_NONE;
    endtask

    // Random stores, one per cycle
    task automatic mark_random_lines(input int n_marks);
        logic [31:0] rnd;
        for (int i = 0; i < n_marks; i++) begin
            @(negedge clk_i);
            rnd          = $urandom_range(flush_pkg::DCACHE_LINES - 1, 0);
            mark_dirty_i = 1'b1;
            mark_line_i  = rnd[flush_pkg::LINE_IDX_WIDTH-1:0];
            model_mark(rnd[flush_pkg::LINE_IDX_WIDTH-1:0]);
        end
        @(negedge clk_i);
        mark_dirty_i = 1'b0;
    endtask

    // Fence after some stores, then compare the write-back stream
    task automatic run_fence(input flush_pkg::commit_op_e op, input int n_marks);
        int exp_count;
        int pos;
        mark_random_lines(n_marks);
        exp_count = model_dirty_count();
        wb_seen.delete();
        issue_op(op);
        // Halt rises together with the strobes
        check_value("halt_o", 32'(halt_o), 32'd1);
        check_value("commit_ready_o", 32'(commit_ready_o), 32'd0);
        @(negedge clk_i);
        check_value("flush_dcache_o", 32'(flush_dcache_o), 32'd1);
        while (halt_o) begin
            check_value("commit_ready_o", 32'(commit_ready_o), 32'd0);
            @(negedge clk_i);
        end
        check_value("commit_ready_o", 32'(commit_ready_o), 32'd1);
        check_value("flush_dcache_o", 32'(flush_dcache_o), 32'd0);
        check_value("writeback_count", 32'(wb_seen.size()), 32'(exp_count));
        // Ascending order, each dirty line once
        pos = 0;
        for (int i = 0; i < flush_pkg::DCACHE_LINES; i++) begin
            if (model_dirty[i]) begin
                check_value("writeback_line_o", 32'(wb_seen[pos]), 32'(i));
                pos++;
            end
        end
        model_dirty = '0;
    endtask

    // ------------------------------
    // Monitors
    // ------------------------------
    // Strobes one cycle after each accepted instruction, zero otherwise
    initial begin : compare_strobes
        logic                  pend;
        flush_pkg::commit_op_e pend_op;
        logic [7:0]            exp;
        pend    = 1'b0;
        pend_op = flush_pkg::OP_NONE;
        @(posedge rst_ni);
        forever begin
            @(negedge clk_i);
            #1;
            exp = pend ? expected_flush(pend_op) : 8'h00;
            check_value("set_pc_commit_o", 32'(set_pc_commit_o), 32'(exp[7]));
            check_value("flush_if_o", 32'(flush_if_o), 32'(exp[6]));
            check_value("flush_unissued_instr_o", 32'(flush_unissued_instr_o), 32'(exp[5]));
            check_value("flush_id_o", 32'(flush_id_o), 32'(exp[4]));
            check_value("flush_ex_o", 32'(flush_ex_o), 32'(exp[3]));
            check_value("flush_bp_o", 32'(flush_bp_o), 32'(exp[2]));
            check_value("flush_icache_o", 32'(flush_icache_o), 32'(exp[1]));
            check_value("flush_tlb_o", 32'(flush_tlb_o), 32'(exp[0]));
            // Handshake for the coming edge
            pend    = commit_valid_i && commit_ready_o;
            pend_op = flush_pkg::commit_op_e'(commit_op_i);
            if (pend) begin
                accepted_count++;
            end
        end
    end

    // Collect write-backs and check that a stalled line holds
    initial begin : watch_writeback
        logic                                 prev_stall;
        logic [flush_pkg::LINE_IDX_WIDTH-1:0] prev_line;
        prev_stall = 1'b0;
        prev_line  = '0;
        @(posedge rst_ni);
        forever begin
            @(negedge clk_i);
            #1;
            if (prev_stall) begin
                check_value("writeback_valid_o", 32'(writeback_valid_o), 32'd1);
                check_value("writeback_line_o", 32'(writeback_line_o), 32'(prev_line));
            end
            if (writeback_valid_o && writeback_ready_i) begin
                wb_seen.push_back(writeback_line_o);
            end
            prev_stall = writeback_valid_o && !writeback_ready_i;
            prev_line  = writeback_line_o;
        end
    end

    // Write-back back-pressure, random only when enabled
    always @(negedge clk_i) begin : drive_wb_ready
        logic [31:0] rnd;
        rnd               = $urandom;
        writeback_ready_i = random_wb_ready ? rnd[0] : 1'b1;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        fail_run("Timeout: the test sequence did not finish within the cycle budget");
    end

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin : main_seq
        logic [31:0]           rnd;
        flush_pkg::commit_op_e op;
        int                    count_before;
        void'($urandom(32'hd55a_aa9a));
        rst_ni            = 1'b0;
        commit_valid_i    = 1'b0;
        commit_op_i       = flush_pkg::OP_NONE;
        halt_csr_i        = 1'b0;
        mark_dirty_i      = 1'b0;
        mark_line_i       = '0;
        writeback_ready_i = 1'b1;
        model_dirty       = '0;
        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        // Idle outputs after reset
        @(negedge clk_i);
        check_value("halt_o", 32'(halt_o), 32'd0);
        check_value("flush_dcache_o", 32'(flush_dcache_o), 32'd0);
        check_value("writeback_valid_o", 32'(writeback_valid_o), 32'd0);
        check_value("commit_ready_o", 32'(commit_ready_o), 32'd1);

        // Random non-fence classes with random gaps
        for (int i = 0; i < NUM_RANDOM_OPS; i++) begin
            rnd = $urandom_range(6, 0);
            case (rnd)
                32'd0:   op = flush_pkg::OP_NONE;
                32'd1:   op = flush_pkg::OP_ALU;
                32'd2:   op = flush_pkg::OP_BRANCH_MISS;
                32'd3:   op = flush_pkg::OP_SFENCE_VMA;
                32'd4:   op = flush_pkg::OP_CSR_WRITE;
                32'd5:   op = flush_pkg::OP_EXCEPTION;
                default: op = flush_pkg::OP_ERET;
            endcase
            issue_op(op);
            repeat ($urandom_range(2, 0)) @(negedge clk_i);
        end

        // Traps flush the predictor and never set the PC
        issue_op(flush_pkg::OP_EXCEPTION);
        check_value("flush_bp_o", 32'(flush_bp_o), 32'd1);
        check_value("set_pc_commit_o", 32'(set_pc_commit_o), 32'd0);
        issue_op(flush_pkg::OP_ERET);
        check_value("flush_bp_o", 32'(flush_bp_o), 32'd1);
        check_value("set_pc_commit_o", 32'(set_pc_commit_o), 32'd0);
        // Mispredict only touches the frontend
        issue_op(flush_pkg::OP_BRANCH_MISS);
        check_value("flush_if_o", 32'(flush_if_o), 32'd1);
        check_value("flush_unissued_instr_o", 32'(flush_unissued_instr_o), 32'd1);
        check_value("flush_id_o", 32'(flush_id_o), 32'd0);
        check_value("set_pc_commit_o", 32'(set_pc_commit_o), 32'd0);

        // Fences with full-rate write-back, second one finds nothing
        run_fence(flush_pkg::OP_FENCE, 6);
        run_fence(flush_pkg::OP_FENCE, 0);
        run_fence(flush_pkg::OP_FENCE_I, 6);
        run_fence(flush_pkg::OP_FENCE_I, 0);

        // Same again under random back-pressure
        random_wb_ready = 1'b1;
        run_fence(flush_pkg::OP_FENCE, 10);
        run_fence(flush_pkg::OP_FENCE_I, 10);
        run_fence(flush_pkg::OP_FENCE, 0);
        random_wb_ready = 1'b0;

        // CSR halt blocks the commit port
        @(negedge clk_i);
        halt_csr_i     = 1'b1;
        commit_valid_i = 1'b1;
        commit_op_i    = flush_pkg::OP_CSR_WRITE;
        count_before   = accepted_count;
        repeat (6) begin
            @(negedge clk_i);
            check_value("commit_ready_o", 32'(commit_ready_o), 32'd0);
        end
        check_value("accepted_count", 32'(accepted_count), 32'(count_before));
        halt_csr_i = 1'b0;
        @(negedge clk_i);
        commit_valid_i = 1'b0;
        commit_op_i    = flush_pkg::OP_NONE;
        check_value("accepted_count", 32'(accepted_count), 32'(count_before + 1));
        repeat (4) @(negedge clk_i);
        check_value("halt_o", 32'(halt_o), 32'd0);

        if (error_count == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("Finished with errors");
            $fatal(1, "Errors were reported during the run");
        end
    end

endmodule

// ==== verilog/commit_event_decoder.sv ====
// Commit event decoder
// Takes committed instructions over a valid/ready port and turns each
// accepted instruction class into a registered one-cycle flush event

`timescale 1ns/1ps

module commit_event_decoder (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    // Commit port
    input  logic                   commit_valid_i,
    input  flush_pkg::commit_op_e  commit_op_i,
    input  logic                   halt_i,
    output logic                   commit_ready_o,
    // Event strobes to the flush controller
    output logic                   mispredict_o,
    output logic                   fence_o,
    output logic                   fence_i_o,
    output logic                   sfence_vma_o,
    output logic                   flush_csr_o,
    output logic                   ex_valid_o,
    output logic                   eret_o
);

    // Event bits msb first are mispredict, fence, fence.i, sfence.vma, csr, exception, eret
    logic [6:0] event_d;
    logic [6:0] event_q;
    logic       accept;

    // No new instruction while the core is halted
    assign commit_ready_o = ~halt_i;
    assign accept         = commit_valid_i & commit_ready_o;

    // ------------------------------
    // Class decode
    // ------------------------------
    always_comb begin
        event_d = 7'b0000000;
        case (commit_op_i)
            flush_pkg::OP_BRANCH_MISS: event_d = 7'b1000000;
            flush_pkg::OP_FENCE:       event_d = 7'b0100000;
            flush_pkg::OP_FENCE_I:     event_d = 7'b0010000;
            flush_pkg::OP_SFENCE_VMA:  event_d = 7'b0001000;
            flush_pkg::OP_CSR_WRITE:   event_d = 7'b0000100;
            flush_pkg::OP_EXCEPTION:   event_d = 7'b0000010;
            flush_pkg::OP_ERET:        event_d = 7'b0000001;
            // ALU and bubbles leave the pipeline alone
            default:                   event_d = 7'b0000000;
        endcase
    end

    // Event lives for exactly one cycle after the accepting edge
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            event_q <= 7'b0000000;
        end else if (accept) begin
            event_q <= event_d;
        end else begin
            event_q <= 7'b0000000;
        end
    end

    assign {mispredict_o, fence_o, fence_i_o, sfence_vma_o,
            flush_csr_o, ex_valid_o, eret_o} = event_q;

    // ------------------------------
    // Assertions
    // ------------------------------
    // Controller relies on a single event per cycle
    a_event_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(event_q));

endmodule

// ==== verilog/dcache_flush_sequencer.sv ====
// Data cache flush sequencer
// Keeps the dirty-line bitmap of a write-back cache and, on a flush request,
// walks all lines in order, streaming each dirty one out for write-back

`timescale 1ns/1ps

module dcache_flush_sequencer (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,
    // Request from the flush controller
    input  logic                                 flush_dcache_i,
    // Store side marks a line dirty
    input  logic                                 mark_dirty_i,
    input  logic [flush_pkg::LINE_IDX_WIDTH-1:0] mark_line_i,
    // Write-back stream
    input  logic                                 writeback_ready_i,
    output logic                                 writeback_valid_o,
    output logic [flush_pkg::LINE_IDX_WIDTH-1:0] writeback_line_o,
    // Done pulse back to the controller
    output logic                                 flush_dcache_ack_o
);

    flush_pkg::dc_state_e                  state_d;
    flush_pkg::dc_state_e                  state_q;
    logic [flush_pkg::LINE_IDX_WIDTH-1:0]  idx_d;
    logic [flush_pkg::LINE_IDX_WIDTH-1:0]  idx_q;
    logic [flush_pkg::DCACHE_LINES-1:0]    dirty_d;
    logic [flush_pkg::DCACHE_LINES-1:0]    dirty_q;
    logic                                  line_done;

    // Current line is offered only if it still holds dirty data
    assign writeback_valid_o  = (state_q == flush_pkg::DC_SCAN) && dirty_q[idx_q];
    assign writeback_line_o   = idx_q;
    assign flush_dcache_ack_o = (state_q == flush_pkg::DC_ACK);

    // Clean lines move on at once, dirty ones wait for the handshake
    assign line_done = !dirty_q[idx_q] || writeback_ready_i;

    // ------------------------------
    // Scan FSM
    // ------------------------------
    always_comb begin
        state_d = state_q;
        idx_d   = idx_q;
        dirty_d = dirty_q;

        case (state_q)
            flush_pkg::DC_IDLE: begin
                if (flush_dcache_i) begin
                    state_d = flush_pkg::DC_SCAN;
                    idx_d   = '0;
                end
            end
            flush_pkg::DC_SCAN: begin
                if (line_done) begin
                    // Transferred line is clean again
                    dirty_d[idx_q] = 1'b0;
                    if (idx_q == flush_pkg::LAST_LINE_IDX) begin
                        state_d = flush_pkg::DC_ACK;
                    end else begin
                        idx_d = idx_q + 1'b1;
                    end
                end
            end
            flush_pkg::DC_ACK: begin
                state_d = flush_pkg::DC_IDLE;
            end
            default: begin
                state_d = flush_pkg::DC_IDLE;
            end
        endcase

        // New store wins over a same-cycle write-back of that line
        if (mark_dirty_i) begin
            dirty_d[mark_line_i] = 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= flush_pkg::DC_IDLE;
            idx_q   <= '0;
            dirty_q <= '0;
        end else begin
            state_q <= state_d;
            idx_q   <= idx_d;
            dirty_q <= dirty_d;
        end
    end

    // ------------------------------
    // Assertions
    // ------------------------------
    // Stalled write-back keeps its line until taken
    a_wb_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        writeback_valid_o && !writeback_ready_i |=>
            writeback_valid_o && $stable(writeback_line_o));

endmodule

// ==== verilog/flush_controller.sv ====
// Pipeline flush controller
// Maps commit events onto per-stage flush strobes and the set-PC strobe,
// keeps a data-cache flush request raised until the cache acknowledges it
// and halts the commit port while that fence is in flight

`timescale 1ns/1ps

module flush_controller (
    input  logic clk_i,
    input  logic rst_ni,
    // Events from the commit decoder
    input  logic mispredict_i,
    input  logic fence_i,
    input  logic fence_i_i,
    input  logic sfence_vma_i,
    input  logic flush_csr_i,
    input  logic ex_valid_i,
    input  logic eret_i,
    // Halt request from the CSR file such as WFI
    input  logic halt_csr_i,
    // Data cache has finished writing back
    input  logic flush_dcache_ack_i,
    // Frontend and pipeline strobes
    output logic set_pc_commit_o,
    output logic flush_if_o,
    output logic flush_unissued_instr_o,
    output logic flush_id_o,
    output logic flush_ex_o,
    output logic flush_bp_o,
    // Cache and TLB maintenance
    output logic flush_icache_o,
    output logic flush_tlb_o,
    output logic flush_dcache_o,
    // Stall for the commit port
    output logic halt_o
);

    flush_pkg::fence_state_e fence_state_d;
    flush_pkg::fence_state_e fence_state_q;
    logic                    flush_dcache;
    logic                    fence_active;

    // ------------------------------
    // Flush decision
    // ------------------------------
    // Later rules override earlier ones
    always_comb begin
        fence_state_d          = fence_state_q;
        set_pc_commit_o        = 1'b0;
        flush_if_o             = 1'b0;
        flush_unissued_instr_o = 1'b0;
        flush_id_o             = 1'b0;
        flush_ex_o             = 1'b0;
        flush_bp_o             = 1'b0;
        flush_icache_o         = 1'b0;
        flush_tlb_o            = 1'b0;
        flush_dcache           = 1'b0;

        // Mispredict only kills what is still in the frontend
        if (mispredict_i) begin
            flush_if_o             = 1'b1;
            flush_unissued_instr_o = 1'b1;
        end

        // FENCE behaves like a CSR write that also drains the data cache
        if (fence_i) begin
            set_pc_commit_o        = 1'b1;
            flush_if_o             = 1'b1;
            flush_unissued_instr_o = 1'b1;
            flush_id_o             = 1'b1;
            flush_ex_o             = 1'b1;
            flush_dcache           = 1'b1;
            fence_state_d          = flush_pkg::FENCE_WAIT_ACK;
        end

        // FENCE.I drains the data cache and drops the icache
        if (fence_i_i) begin
            set_pc_commit_o        = 1'b1;
            flush_if_o             = 1'b1;
            flush_unissued_instr_o = 1'b1;
            flush_id_o             = 1'b1;
            flush_ex_o             = 1'b1;
            flush_icache_o         = 1'b1;
            flush_dcache           = 1'b1;
            fence_state_d          = flush_pkg::FENCE_WAIT_ACK;
        end

        // Hold the request until the sequencer is done
        if (fence_state_q == flush_pkg::FENCE_WAIT_ACK) begin
            if (flush_dcache_ack_i) begin
                fence_state_d = flush_pkg::FENCE_IDLE;
            end else begin
                flush_dcache = 1'b1;
            end
        end

        // SFENCE.VMA restarts from commit with fresh translations
        if (sfence_vma_i) begin
            set_pc_commit_o        = 1'b1;
            flush_if_o             = 1'b1;
            flush_unissued_instr_o = 1'b1;
            flush_id_o             = 1'b1;
            flush_ex_o             = 1'b1;
            flush_tlb_o            = 1'b1;
        end

        // CSR side effects
        if (flush_csr_i) begin
            set_pc_commit_o        = 1'b1;
            flush_if_o             = 1'b1;
            flush_unissued_instr_o = 1'b1;
            flush_id_o             = 1'b1;
            flush_ex_o             = 1'b1;
        end

        // Trap entry and return take the PC from the CSR file
        if (ex_valid_i || eret_i) begin
            set_pc_commit_o        = 1'b0;
            flush_if_o             = 1'b1;
            flush_unissued_instr_o = 1'b1;
            flush_id_o             = 1'b1;
            flush_ex_o             = 1'b1;
            flush_bp_o             = 1'b1;
        end
    end

    // ------------------------------
    // Halt
    // ------------------------------
    // The fence event itself counts so commit stops in the strobe cycle
    assign fence_active = (fence_state_q == flush_pkg::FENCE_WAIT_ACK) | fence_i | fence_i_i;
    assign halt_o       = halt_csr_i | fence_active;

    // ------------------------------
    // Registers
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fence_state_q  <= flush_pkg::FENCE_IDLE;
            flush_dcache_o <= 1'b0;
        end else begin
            fence_state_q  <= fence_state_d;
            // Registered request toward the sequencer
            flush_dcache_o <= flush_dcache;
        end
    end

    // ------------------------------
    // Assertions
    // ------------------------------
    a_ack_while_waiting: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_dcache_ack_i |-> fence_state_q == flush_pkg::FENCE_WAIT_ACK);

endmodule

// ==== verilog/flush_pkg.sv ====
// Flush unit package
// Shared sizes, the committed instruction class and the FSM state encodings
// for the commit decoder, the flush controller and the data-cache sequencer

package flush_pkg;

    // ------------------------------
    // Sizes
    // ------------------------------
    // Width of the committed opcode port
    localparam int OP_WIDTH = 4;

    // Data cache geometry, one dirty bit per line
    localparam int DCACHE_LINES   = 16;
    localparam int LINE_IDX_WIDTH = 4;

    // Index of the final line visited by a flush scan
    localparam logic [LINE_IDX_WIDTH-1:0] LAST_LINE_IDX = LINE_IDX_WIDTH'(DCACHE_LINES - 1);

    // ------------------------------
    // Committed instruction class
    // ------------------------------
    typedef enum logic [OP_WIDTH-1:0] {
        OP_NONE        = 4'd0,
        OP_ALU         = 4'd1,
        OP_BRANCH_MISS = 4'd2,
        OP_FENCE       = 4'd3,
        OP_FENCE_I     = 4'd4,
        OP_SFENCE_VMA  = 4'd5,
        OP_CSR_WRITE   = 4'd6,
        OP_EXCEPTION   = 4'd7,
        OP_ERET        = 4'd8
    } commit_op_e;

    // ------------------------------
    // FSM states
    // ------------------------------
    // Controller side, high while a data-cache flush is outstanding
    typedef enum logic [0:0] {
        FENCE_IDLE     = 1'b0,
        FENCE_WAIT_ACK = 1'b1
    } fence_state_e;

    // Data-cache flush sequencer
    typedef enum logic [1:0] {
        DC_IDLE = 2'd0,
        DC_SCAN = 2'd1,
        DC_ACK  = 2'd2
    } dc_state_e;

endpackage

// ==== verilog/flush_unit_top.sv ====
// Pipeline flush unit
// Commit-side event decoder, flush controller and write-back data cache
// flush sequencer joined into one block

`timescale 1ns/1ps

module flush_unit_top (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,
    // Commit port
    input  logic                                 commit_valid_i,
    input  logic [flush_pkg::OP_WIDTH-1:0]       commit_op_i,
    output logic                                 commit_ready_o,
    // CSR halt request
    input  logic                                 halt_csr_i,
    // Dirty marks from the store path
    input  logic                                 mark_dirty_i,
    input  logic [flush_pkg::LINE_IDX_WIDTH-1:0] mark_line_i,
    // Write-back stream
    input  logic                                 writeback_ready_i,
    output logic                                 writeback_valid_o,
    output logic [flush_pkg::LINE_IDX_WIDTH-1:0] writeback_line_o,
    // Flush strobes
    output logic                                 set_pc_commit_o,
    output logic                                 flush_if_o,
    output logic                                 flush_unissued_instr_o,
    output logic                                 flush_id_o,
    output logic                                 flush_ex_o,
    output logic                                 flush_bp_o,
    output logic                                 flush_icache_o,
    output logic                                 flush_tlb_o,
    output logic                                 flush_dcache_o,
    output logic                                 halt_o
);

    flush_pkg::commit_op_e commit_op;
    logic                  mispredict;
    logic                  fence;
    logic                  fence_i;
    logic                  sfence_vma;
    logic                  flush_csr;
    logic                  ex_valid;
    logic                  eret;
    logic                  flush_dcache_ack;

    // Raw opcode bits into the class encoding
    assign commit_op = flush_pkg::commit_op_e'(commit_op_i);

    // ------------------------------
    // Producer
    // ------------------------------
    commit_event_decoder u_decoder (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .commit_valid_i (commit_valid_i),
        .commit_op_i    (commit_op),
        .halt_i         (halt_o),
        .commit_ready_o (commit_ready_o),
        .mispredict_o   (mispredict),
        .fence_o        (fence),
        .fence_i_o      (fence_i),
        .sfence_vma_o   (sfence_vma),
        .flush_csr_o    (flush_csr),
        .ex_valid_o     (ex_valid),
        .eret_o         (eret)
    );

    // ------------------------------
    // Controller
    // ------------------------------
    flush_controller u_flush_ctrl (
        .clk_i                  (clk_i),
        .rst_ni                 (rst_ni),
        .mispredict_i           (mispredict),
        .fence_i                (fence),
        .fence_i_i              (fence_i),
        .sfence_vma_i           (sfence_vma),
        .flush_csr_i            (flush_csr),
        .ex_valid_i             (ex_valid),
        .eret_i                 (eret),
        .halt_csr_i             (halt_csr_i),
        .flush_dcache_ack_i     (flush_dcache_ack),
        .set_pc_commit_o        (set_pc_commit_o),
        .flush_if_o             (flush_if_o),
        .flush_unissued_instr_o (flush_unissued_instr_o),
        .flush_id_o             (flush_id_o),
        .flush_ex_o             (flush_ex_o),
        .flush_bp_o             (flush_bp_o),
        .flush_icache_o         (flush_icache_o),
        .flush_tlb_o            (flush_tlb_o),
        .flush_dcache_o         (flush_dcache_o),
        .halt_o                 (halt_o)
    );

    // ------------------------------
    // Consumer
    // ------------------------------
    dcache_flush_sequencer u_dc_seq (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .flush_dcache_i     (flush_dcache_o),
        .mark_dirty_i       (mark_dirty_i),
        .mark_line_i        (mark_line_i),
        .writeback_ready_i  (writeback_ready_i),
        .writeback_valid_o  (writeback_valid_o),
        .writeback_line_o   (writeback_line_o),
        .flush_dcache_ack_o (flush_dcache_ack)
    );

endmodule
